// ==== flist.f ====
src/csi_rx_pkg.sv
src/csi_hdr_if.sv
src/dphy_byte_align.sv
src/csi_pkt_parser.sv
src/rx_csr.sv
src/csi_rx_lane.sv
sim/csi_rx_props.sv
sim/tb_csi_rx.sv

// ==== Bender.yml ====
package:
  name: csi_rx_lane

sources:
  - src/csi_rx_pkg.sv
  - src/csi_hdr_if.sv
  - src/dphy_byte_align.sv
  - src/csi_pkt_parser.sv
  - src/rx_csr.sv
  - src/csi_rx_lane.sv
  - target: simulation
    files:
      - sim/csi_rx_props.sv
      - sim/tb_csi_rx.sv

// ==== sim/tb_csi_rx.sv ====
`timescale 1ns/1ps

module tb_csi_rx;

  localparam int N_TESTS      = 6;
  localparam int DRAIN_CYCLES = 20;

  logic                         clk_i;
  logic                         rst_i;
  logic [7:0]                   unaligned_byte_i;
  logic                         cfg_vc_en_i;
  logic [1:0]                   cfg_vc_i;
  logic                         clear_counts_i;
  logic                         pkt_valid_o;
  csi_rx_pkg::csi_dt_e          pkt_dt_o;
  logic [1:0]                   pkt_vc_o;
  logic [15:0]                  pkt_wc_o;
  logic                         payload_valid_o;
  logic [7:0]                   payload_byte_o;
  logic [csi_rx_pkg::CNT_W-1:0] pkt_count_o;
  logic [csi_rx_pkg::CNT_W-1:0] ecc_err_count_o;

  logic [31:0]         rng_state = 32'h68db_9480;
  bit                  bit_q [$];
  logic [7:0]          stream_q [$];    // Serial bytes for the whole run.
  csi_rx_pkg::csi_dt_e exp_dt_q [$];
  logic [1:0]          exp_vc_q [$];
  logic [15:0]         exp_wc_q [$];
  logic [7:0]          exp_byte_q [$];
  int                  test_len [N_TESTS];
  int                  pkt_mark [N_TESTS];
  int                  byte_mark [N_TESTS];
  int                  pkt_tally [N_TESTS];
  int                  ecc_tally [N_TESTS];
  bit                  cfg_en [N_TESTS];
  bit [1:0]            cfg_vc [N_TESTS];
  string               test_name [N_TESTS];
  int                  tally_pkt;
  int                  tally_ecc;
  int                  got_pkts;
  int                  got_bytes;
  int                  err_count;
  int                  passed;
  int                  watch_cycles;
  bit                  gen_done;

  csi_rx_lane uut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .unaligned_byte_i (unaligned_byte_i),
    .cfg_vc_en_i      (cfg_vc_en_i),
    .cfg_vc_i         (cfg_vc_i),
    .clear_counts_i   (clear_counts_i),
    .pkt_valid_o      (pkt_valid_o),
    .pkt_dt_o         (pkt_dt_o),
    .pkt_vc_o         (pkt_vc_o),
    .pkt_wc_o         (pkt_wc_o),
    .payload_valid_o  (payload_valid_o),
    .payload_byte_o   (payload_byte_o),
    .pkt_count_o      (pkt_count_o),
    .ecc_err_count_o  (ecc_err_count_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
  endfunction

  function automatic csi_rx_pkg::csi_dt_e pick_dt(input bit long_pkt);
    case (rand_range(0, 3))
      0:       return long_pkt ? csi_rx_pkg::DT_YUV422_8 : csi_rx_pkg::DT_FS;
      1:       return long_pkt ? csi_rx_pkg::DT_RGB888 : csi_rx_pkg::DT_FE;
      2:       return long_pkt ? csi_rx_pkg::DT_RAW8 : csi_rx_pkg::DT_LS;
      default: return long_pkt ? csi_rx_pkg::DT_RAW10 : csi_rx_pkg::DT_LE;
    endcase
  endfunction

  // Hamming parity rows P0 to P5 from the CSI-2 header ECC table.
  function automatic logic [5:0] header_parity(input logic [23:0] d);
    logic [23:0] rows [6];
    logic [5:0]  p;
    rows = '{24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
    for (int k = 0; k < 6; k++)
    begin
      p[k] = ^(d & rows[k]);
    end
    return p;
  endfunction

  task automatic add_byte(input logic [7:0] v);
    for (int i = 0; i < 8; i++)
    begin
      bit_q.push_back(v[i]);  // Least significant bit goes first on the wire.
    end
  endtask

  task automatic build_burst(input int t, input int lead, input bit long_pkt,
                             input logic [1:0] vc, input bit flip);
    csi_rx_pkg::csi_dt_e dt;
    logic [15:0]         wc;
    logic [7:0]          di;
    logic [7:0]          ecc;
    logic [7:0]          pay [$];
    logic [7:0]          b;
    bit                  take;
    dt  = pick_dt(long_pkt);
    wc  = long_pkt ? 16'(rand_range(1, 24)) : 16'(lcg_next());
    di  = {vc, dt};
    ecc = {2'b00, header_parity({wc, di})};
    if (flip)
      ecc = ecc ^ (8'h01 << rand_range(0, 7));
    bit_q.delete();
    repeat (lead) bit_q.push_back(1'b0);
    add_byte(csi_rx_pkg::SYNC_PATTERN);
    add_byte(di);
    add_byte(wc[7:0]);
    add_byte(wc[15:8]);
    add_byte(ecc);
    if (long_pkt)
    begin
      repeat (wc)
      begin
        b = 8'(lcg_next() >> 16);
        pay.push_back(b);
        add_byte(b);
      end
      repeat (csi_rx_pkg::CRC_BYTES) add_byte(8'(lcg_next() >> 16));
    end
    repeat (24) add_byte(8'h00);
    while (bit_q.size() > 0)
    begin
      b = 8'h00;
      for (int i = 0; i < 8; i++)
      begin
        if (bit_q.size() > 0)
          b[i] = bit_q.pop_front();
      end
      stream_q.push_back(b);
      test_len[t]++;
    end
    take = !flip && (!cfg_en[t] || vc == cfg_vc[t]);
    if (take)
    begin
      exp_dt_q.push_back(dt);
      exp_vc_q.push_back(vc);
      exp_wc_q.push_back(wc);
      foreach (pay[i])
        exp_byte_q.push_back(pay[i]);
      tally_pkt++;
    end
    if (flip)
      tally_ecc++;
  endtask

  task automatic mark_test(input int t);
    pkt_mark[t]  = exp_dt_q.size();
    byte_mark[t] = exp_byte_q.size();
    pkt_tally[t] = tally_pkt;
    ecc_tally[t] = tally_ecc;
  endtask

  task automatic generate_all();
    test_name = '{"sync offsets", "long payload", "back to back",
                  "ecc error", "vc filter", "counter clear"};
    cfg_en[4] = 1'b1;
    cfg_vc[4] = 2'(rand_range(0, 3));
    for (int o = 0; o < 8; o++)
    begin
      build_burst(0, 8 + o + 8 * rand_range(0, 3), 1'b0, 2'(rand_range(0, 3)), 1'b0);
    end
    mark_test(0);
    repeat (4) build_burst(1, rand_range(8, 40), 1'b1, 2'(rand_range(0, 3)), 1'b0);
    mark_test(1);
    repeat (6) build_burst(2, rand_range(8, 40), rand_range(0, 1) == 1, 2'(rand_range(0, 3)), 1'b0);
    mark_test(2);
    build_burst(3, rand_range(8, 40), 1'b1, 2'(rand_range(0, 3)), 1'b1);
    build_burst(3, rand_range(8, 40), 1'b1, 2'(rand_range(0, 3)), 1'b0);
    mark_test(3);
    build_burst(4, rand_range(8, 40), 1'b1, cfg_vc[4], 1'b0);
    repeat (5) build_burst(4, rand_range(8, 40), rand_range(0, 1) == 1, 2'(rand_range(0, 3)), 1'b0);
    mark_test(4);
    build_burst(5, rand_range(8, 40), 1'b1, 2'(rand_range(0, 3)), 1'b0);
    build_burst(5, rand_range(8, 40), 1'b0, 2'(rand_range(0, 3)), 1'b1);
    build_burst(5, rand_range(8, 40), 1'b0, 2'(rand_range(0, 3)), 1'b0);
    mark_test(5);
  endtask

  task automatic check_pkt(input csi_rx_pkg::csi_dt_e got_dt, input csi_rx_pkg::csi_dt_e exp_dt,
                           input logic [1:0] got_vc, input logic [1:0] exp_vc,
                           input logic [15:0] got_wc, input logic [15:0] exp_wc);
    if (got_dt !== exp_dt)
    begin
      $display("MISMATCH pkt_dt_o got 0x%h expected 0x%h", got_dt, exp_dt);
      err_count++;
    end
    if (got_vc !== exp_vc)
    begin
      $display("MISMATCH pkt_vc_o got 0x%h expected 0x%h", got_vc, exp_vc);
      err_count++;
    end
    if (got_wc !== exp_wc)
    begin
      $display("MISMATCH pkt_wc_o got 0x%h expected 0x%h", got_wc, exp_wc);
      err_count++;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH payload_byte_o got 0x%h expected 0x%h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input logic [csi_rx_pkg::CNT_W-1:0] got,
                             input logic [csi_rx_pkg::CNT_W-1:0] exp, input string name);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  // Outputs come from registers, so the middle of the cycle is a safe sample point.
  always @(negedge clk_i)
  begin
    if (pkt_valid_o === 1'b1)
    begin
      if (exp_dt_q.size() == 0)
      begin
        $display("packet of type 0x%h reported where none was expected", pkt_dt_o);
        err_count++;
      end
      else
        check_pkt(pkt_dt_o, exp_dt_q.pop_front(), pkt_vc_o, exp_vc_q.pop_front(),
                  pkt_wc_o, exp_wc_q.pop_front());
      got_pkts++;
    end
    if (payload_valid_o === 1'b1)
    begin
      if (exp_byte_q.size() == 0)
      begin
        $display("payload byte 0x%h forwarded where none was expected", payload_byte_o);
        err_count++;
      end
      else
        check_byte(payload_byte_o, exp_byte_q.pop_front());
      got_bytes++;
    end
  end

  task automatic wait_drained(input int t);
    int n;
    n = 0;
    while ((got_pkts < pkt_mark[t] || got_bytes < byte_mark[t]) && n < DRAIN_CYCLES)
    begin
      @(negedge clk_i);
      n++;
    end
    if (got_pkts < pkt_mark[t] || got_bytes < byte_mark[t])
    begin
      $display("test %0d ended with %0d packets and %0d payload bytes never received",
               t, pkt_mark[t] - got_pkts, byte_mark[t] - got_bytes);
      err_count++;
    end
  endtask

  task automatic run_test(input int t);
    int errs_before;
    errs_before = err_count;
    @(negedge clk_i);
    cfg_vc_en_i = cfg_en[t];
    cfg_vc_i    = cfg_vc[t];
    repeat (test_len[t])
    begin
      @(negedge clk_i);
      unaligned_byte_i = stream_q.pop_front();
    end
    @(negedge clk_i);
    unaligned_byte_i = 8'h00;
    wait_drained(t);
    check_count(pkt_count_o, pkt_tally[t], "pkt_count_o");
    check_count(ecc_err_count_o, ecc_tally[t], "ecc_err_count_o");
    if (t == N_TESTS - 1)
    begin
      @(negedge clk_i);
      clear_counts_i = 1'b1;
      @(negedge clk_i);
      clear_counts_i = 1'b0;
      @(negedge clk_i);
      check_count(pkt_count_o, '0, "pkt_count_o");
      check_count(ecc_err_count_o, '0, "ecc_err_count_o");
    end
    if (err_count == errs_before)
    begin
      $display("test %0d %s: ok", t, test_name[t]);
      passed++;
    end
    else
      $display("test %0d %s: failed with %0d errors", t, test_name[t], err_count - errs_before);
  endtask

  initial
  begin
    wait (gen_done);
    repeat (watch_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles without the run finishing", watch_cycles);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    rst_i            = 1'b1;
    unaligned_byte_i = 8'h00;
    cfg_vc_en_i      = 1'b0;
    cfg_vc_i         = 2'd0;
    clear_counts_i   = 1'b0;
    generate_all();
    watch_cycles = stream_q.size() + 200;
    gen_done     = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    for (int t = 0; t < N_TESTS; t++)
    begin
      run_test(t);
    end
    $display("%0d of %0d tests passed, %0d failed, %0d errors",
             passed, N_TESTS, N_TESTS - passed, err_count);
    if (err_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== sim/csi_rx_props.sv ====
`timescale 1ns/1ps

module csi_rx_props (
  input logic                     clk_i,
  input logic                     rst_i,
  input csi_rx_pkg::parse_state_e state_i,
  input logic                     payload_valid_i,
  input logic                     realign_i,
  input logic                     pkt_valid_i,
  input logic [23:0]              hdr_data_i,
  input logic [7:0]               ecc_byte_i
);

  no_payload_in_hunt: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == csi_rx_pkg::ST_HUNT) |=> !payload_valid_i)
    else $error("payload strobe straight after the parser hunted for a header");

  realign_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    realign_i |=> !realign_i)
    else $error("re-hunt request held longer than one cycle");

  // The ECC byte is still in the payload register while the header is reported.
  pkt_needs_good_ecc: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_valid_i |-> (ecc_byte_i == {2'b00, csi_rx_pkg::csi_ecc(hdr_data_i)}))
    else $error("packet reported with a failed header ECC");

endmodule

bind csi_pkt_parser csi_rx_props u_props (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .state_i         (state),
  .payload_valid_i (payload_valid_o),
  .realign_i       (realign_o),
  .pkt_valid_i     (pkt_valid_o),
  .hdr_data_i      (hdr_data),
  .ecc_byte_i      (byte_d)
);

// ==== src/csi_rx_lane.sv ====
`timescale 1ns/1ps

module csi_rx_lane (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [7:0]                   unaligned_byte_i,
  input  logic                         cfg_vc_en_i,
  input  logic [1:0]                   cfg_vc_i,
  input  logic                         clear_counts_i,
  output logic                         pkt_valid_o,
  output csi_rx_pkg::csi_dt_e          pkt_dt_o,
  output logic [1:0]                   pkt_vc_o,
  output logic [15:0]                  pkt_wc_o,
  output logic                         payload_valid_o,
  output logic [7:0]                   payload_byte_o,
  output logic [csi_rx_pkg::CNT_W-1:0] pkt_count_o,
  output logic [csi_rx_pkg::CNT_W-1:0] ecc_err_count_o
);

  logic       align_valid;
  logic [7:0] align_byte;
  logic       realign;

  csi_hdr_if hdr_if ();

  dphy_byte_align u_align (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .unaligned_byte_i (unaligned_byte_i),
    .reset_align_i    (realign),
    .valid_o          (align_valid),
    .aligned_byte_o   (align_byte)
  );

  csi_pkt_parser u_parser (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .byte_valid_i    (align_valid),
    .byte_i          (align_byte),
    .hdr             (hdr_if.parser),
    .realign_o       (realign),
    .pkt_valid_o     (pkt_valid_o),
    .pkt_dt_o        (pkt_dt_o),
    .pkt_vc_o        (pkt_vc_o),
    .pkt_wc_o        (pkt_wc_o),
    .payload_valid_o (payload_valid_o),
    .payload_byte_o  (payload_byte_o)
  );

  rx_csr u_csr (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .cfg_vc_en_i     (cfg_vc_en_i),
    .cfg_vc_i        (cfg_vc_i),
    .clear_counts_i  (clear_counts_i),
    .hdr             (hdr_if.csr),
    .pkt_count_o     (pkt_count_o),
    .ecc_err_count_o (ecc_err_count_o)
  );

endmodule

// ==== src/rx_csr.sv ====
`timescale 1ns/1ps

module rx_csr (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cfg_vc_en_i,
  input  logic [1:0]                   cfg_vc_i,
  input  logic                         clear_counts_i,
  csi_hdr_if.csr                       hdr,
  output logic [csi_rx_pkg::CNT_W-1:0] pkt_count_o,
  output logic [csi_rx_pkg::CNT_W-1:0] ecc_err_count_o
);

  logic                        vc_en_q;
  logic [csi_rx_pkg::VC_W-1:0] vc_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      vc_en_q <= 1'b0;
      vc_q    <= '0;
    end
    else
    begin
      vc_en_q <= cfg_vc_en_i;
      vc_q    <= cfg_vc_i;
    end
  end

  assign hdr.accept = !vc_en_q || (hdr.vc == vc_q);

  always_ff @(posedge clk_i)
  begin
    if (rst_i || clear_counts_i)
    begin
      pkt_count_o     <= '0;
      ecc_err_count_o <= '0;
    end
    else if (hdr.hdr_valid)
    begin
      if (hdr.ecc_ok && hdr.accept && pkt_count_o != '1)
        pkt_count_o <= pkt_count_o + 1'b1;  // Saturates.
      if (!hdr.ecc_ok && ecc_err_count_o != '1)
        ecc_err_count_o <= ecc_err_count_o + 1'b1;
    end
  end

endmodule

// ==== src/csi_pkt_parser.sv ====
`timescale 1ns/1ps

module csi_pkt_parser (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        byte_valid_i,
  input  logic [7:0]                  byte_i,
  csi_hdr_if.parser                   hdr,
  output logic                        realign_o,
  output logic                        pkt_valid_o,
  output csi_rx_pkg::csi_dt_e         pkt_dt_o,
  output logic [1:0]                  pkt_vc_o,
  output logic [15:0]                 pkt_wc_o,
  output logic                        payload_valid_o,
  output logic [7:0]                  payload_byte_o
);

  localparam logic [csi_rx_pkg::WC_W:0] CRC_LOAD = (csi_rx_pkg::WC_W + 1)'(csi_rx_pkg::CRC_BYTES);
  localparam logic [1:0] LAST_HDR = 2'(csi_rx_pkg::HDR_BYTES - 1);

  csi_rx_pkg::parse_state_e    state;
  logic [1:0]                  hdr_idx;
  logic [23:0]                 hdr_data;   // DI, WC low, WC high.
  logic                        hdr_valid_q;
  logic                        ecc_ok_q;
  logic [csi_rx_pkg::WC_W:0]   cnt;
  logic                        realign_q;
  logic                        valid_d;
  logic [7:0]                  byte_d;
  logic                        is_long;
  logic                        fwd;

  assign hdr.hdr_valid  = hdr_valid_q;
  assign hdr.data_type  = csi_rx_pkg::csi_dt_e'(hdr_data[5:0]);
  assign hdr.vc         = hdr_data[7:6];
  assign hdr.word_count = hdr_data[23:8];
  assign hdr.ecc_ok     = ecc_ok_q;

  assign is_long     = 8'(hdr_data[5:0]) > csi_rx_pkg::SHORT_DT_MAX;
  assign fwd         = ecc_ok_q && hdr.accept;
  assign pkt_valid_o = hdr_valid_q && fwd;
  assign realign_o   = (hdr_valid_q && !(is_long && fwd)) || realign_q;

  assign pkt_dt_o = hdr.data_type;
  assign pkt_vc_o = hdr.vc;
  assign pkt_wc_o = hdr.word_count;

  // Payload runs one byte behind the input so the accept decision comes first.
  always_ff @(posedge clk_i)
  begin
    byte_d <= byte_i;
  end

  assign payload_valid_o = (state == csi_rx_pkg::ST_PAYLOAD) && valid_d;
  assign payload_byte_o  = byte_d;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state       <= csi_rx_pkg::ST_HUNT;
      hdr_idx     <= 2'd0;
      hdr_valid_q <= 1'b0;
      ecc_ok_q    <= 1'b0;
      cnt         <= '0;
      realign_q   <= 1'b0;
      valid_d     <= 1'b0;
    end
    else
    begin
      valid_d     <= byte_valid_i;
      hdr_valid_q <= 1'b0;
      realign_q   <= 1'b0;
      case (state)
        csi_rx_pkg::ST_HUNT:
        begin
          if (byte_valid_i && !realign_o)  // Skip the byte still locked before re-hunt.
          begin
            hdr_data[7:0] <= byte_i;
            hdr_idx       <= 2'd1;
            state         <= csi_rx_pkg::ST_HDR;
          end
        end
        csi_rx_pkg::ST_HDR:
        begin
          if (hdr_valid_q)
          begin
            if (!is_long)
              state <= csi_rx_pkg::ST_HUNT;
            else if (!fwd)
            begin
              // Wait out payload and CRC, then re-hunt again to drop a false lock.
              state <= csi_rx_pkg::ST_DROP;
              cnt   <= {1'b0, hdr_data[23:8]} + CRC_LOAD;
            end
            else if (hdr_data[23:8] == '0)
            begin
              state <= csi_rx_pkg::ST_CRC;
              cnt   <= CRC_LOAD;
            end
            else
            begin
              state <= csi_rx_pkg::ST_PAYLOAD;
              cnt   <= {1'b0, hdr_data[23:8]};
            end
          end
          else if (byte_valid_i)
          begin
            if (hdr_idx == LAST_HDR)
            begin
              ecc_ok_q    <= byte_i == {2'b00, csi_rx_pkg::csi_ecc(hdr_data)};
              hdr_valid_q <= 1'b1;
            end
            else
            begin
              hdr_data[hdr_idx*8 +: 8] <= byte_i;
              hdr_idx                  <= hdr_idx + 2'd1;
            end
          end
        end
        csi_rx_pkg::ST_PAYLOAD:
        begin
          if (valid_d)
          begin
            if (cnt == 'd1)
            begin
              state <= csi_rx_pkg::ST_CRC;
              cnt   <= CRC_LOAD;
            end
            else
              cnt <= cnt - 'd1;
          end
        end
        csi_rx_pkg::ST_CRC:
        begin
          if (valid_d)
          begin
            if (cnt == 'd1)
            begin
              state     <= csi_rx_pkg::ST_HUNT;
              realign_q <= 1'b1;
            end
            else
              cnt <= cnt - 'd1;
          end
        end
        csi_rx_pkg::ST_DROP:
        begin
          if (cnt == 'd1)  // Counts clocks, the aligner is unlocked here.
          begin
            state     <= csi_rx_pkg::ST_HUNT;
            realign_q <= 1'b1;
          end
          else
            cnt <= cnt - 'd1;
        end
        default:
          state <= csi_rx_pkg::ST_HUNT;
      endcase
    end
  end

endmodule

// ==== src/dphy_byte_align.sv ====
`timescale 1ns/1ps

module dphy_byte_align (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [7:0] unaligned_byte_i,
  input  logic       reset_align_i,
  output logic       valid_o,
  output logic [7:0] aligned_byte_o
);

  logic [7:0]  byte_d1;
  logic [7:0]  byte_d2;
  logic [15:0] window;
  logic        found_sync;
  logic [2:0]  sync_offset;
  logic [2:0]  align_shift;
  logic        sync_done;

  always_ff @(posedge clk_i)
  begin
    byte_d1 <= unaligned_byte_i;
    byte_d2 <= byte_d1;
  end

  assign window = {byte_d1, byte_d2};  // Older byte holds the earlier bits.

  // Lowest matching offset wins.
  always_comb
  begin
    found_sync  = 1'b0;
    sync_offset = 3'd0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == csi_rx_pkg::SYNC_PATTERN)
      begin
        found_sync  = 1'b1;
        sync_offset = 3'(i);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      sync_done   <= 1'b0;
      align_shift <= 3'd0;
    end
    else if (reset_align_i)
    begin
      sync_done <= 1'b0;  // Re-hunt has priority over a match.
    end
    else if (!sync_done && found_sync)
    begin
      sync_done   <= 1'b1;
      align_shift <= sync_offset;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i || reset_align_i)
    begin
      valid_o <= 1'b0;
    end
    else
    begin
      valid_o <= sync_done;
    end
  end

  // First byte out with valid_o is the one after the sync byte.
  always_ff @(posedge clk_i)
  begin
    aligned_byte_o <= window[align_shift +: 8];
  end

endmodule

// ==== src/csi_hdr_if.sv ====
`timescale 1ns/1ps

interface csi_hdr_if;

  logic                              hdr_valid;  // One cycle per decoded header.
  csi_rx_pkg::csi_dt_e               data_type;
  logic [csi_rx_pkg::VC_W-1:0]       vc;
  logic [csi_rx_pkg::WC_W-1:0]       word_count;
  logic                              ecc_ok;
  logic                              accept;     // Same cycle as hdr_valid.

  modport parser (
    output hdr_valid,
    output data_type,
    output vc,
    output word_count,
    output ecc_ok,
    input  accept
  );

  modport csr (
    input  hdr_valid,
    input  vc,
    input  ecc_ok,
    output accept
  );

endinterface

// ==== src/csi_rx_pkg.sv ====
package csi_rx_pkg;

  localparam logic [7:0] SYNC_PATTERN = 8'hB8;
  localparam int         HDR_BYTES    = 4;
  localparam int         CRC_BYTES    = 2;
  localparam logic [7:0] SHORT_DT_MAX = 8'h0F;

  localparam int DT_W  = 6;
  localparam int VC_W  = 2;
  localparam int WC_W  = 16;
  localparam int CNT_W = 16;

  // Parity masks over {wc_high, wc_low, di}, one row per ECC bit.
  localparam logic [5:0][23:0] ECC_MASK = {
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  typedef enum logic [DT_W-1:0] {
    DT_FS       = 6'h00,
    DT_FE       = 6'h01,
    DT_LS       = 6'h02,
    DT_LE       = 6'h03,
    DT_YUV422_8 = 6'h1E,
    DT_RGB888   = 6'h24,
    DT_RAW8     = 6'h2A,
    DT_RAW10    = 6'h2B
  } csi_dt_e;

  typedef enum logic [2:0] {
    ST_HUNT,
    ST_HDR,
    ST_PAYLOAD,
    ST_CRC,
    ST_DROP
  } parse_state_e;

  function automatic logic [5:0] csi_ecc(input logic [23:0] data);
    logic [5:0] ecc;
    for (int i = 0; i < 6; i++)
    begin
      ecc[i] = ^(data & ECC_MASK[i]);
    end
    return ecc;
  endfunction

endpackage
